// File: flist.f
+incdir+.
rat_pkg.sv
rat_entry.sv
rat_bank.sv
rat_bypass.sv
rat.sv
rat_checker.sv
tb_rat.sv

// File: run.sh
#!/bin/sh
# build and run the rat testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_rat -f flist.f -o tb_rat_sim
./obj_dir/tb_rat_sim > sim.log 2>&1
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
  exit 0
fi
exit 1

// File: tb_rat.sv
`timescale 1ns/1ps
`include "rat_defs.svh"

module tb_rat;

  localparam int NUM_CYCLES = 2000;

  logic                  clk;
  logic                  rst;
  logic                  clk_en;
  logic                  retire_all;
  rat_pkg::areg_t        read_areg [`RAT_RD_PORTS];
  rat_pkg::rename_slot_t rename [`RAT_WR_PORTS];
  rat_pkg::retire_slot_t retire [`RAT_RET_PORTS];
  rat_pkg::read_result_t read_result [`RAT_RD_PORTS];
  int                    cmp_errors;
  int                    checks;
  int                    start_checks;
  int                    timeouts = 0;
  logic [`RAT_TAG_W-1:0] recent [$];

  rat i_rat (
    .clk        (clk),
    .rst        (rst),
    .clk_en     (clk_en),
    .read_areg  (read_areg),
    .rename     (rename),
    .retire     (retire),
    .retire_all (retire_all),
    .read_result(read_result)
  );

  rat_checker i_checker (
    .clk        (clk),
    .rst        (rst),
    .clk_en     (clk_en),
    .read_areg  (read_areg),
    .rename     (rename),
    .retire     (retire),
    .retire_all (retire_all),
    .read_result(read_result),
    .errors     (cmp_errors),
    .checks     (checks)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_idle();
    clk_en = 1'b0;
    retire_all = 1'b0;
    for (int i = 0; i < `RAT_RD_PORTS; i++)
      read_areg[i] = '0;
    for (int i = 0; i < `RAT_WR_PORTS; i++)
      rename[i] = '0;
    for (int i = 0; i < `RAT_RET_PORTS; i++)
      retire[i] = '0;
  endtask

  task automatic drive_random();
    logic [31:0] r;
    int base;
    int g [`RAT_WR_PORTS];
    clk_en = ($urandom % 10) < 8;
    retire_all = ($urandom % 50) == 0;
    // three distinct group positions
    base = $urandom % 16;
    g[0] = base;
    g[1] = (base + 1 + $urandom % 7) % 16;
    g[2] = (base + 8 + $urandom % 7) % 16;
    for (int p = 0; p < `RAT_RD_PORTS; p++)
    begin
      if (($urandom % 5) == 0)
        read_areg[p] = rat_pkg::areg_t'(48 + $urandom % 16);
      else
        read_areg[p] = rat_pkg::areg_t'($urandom % `RAT_NUM_AREGS);
    end
    for (int s = 0; s < `RAT_WR_PORTS; s++)
    begin
      r = $urandom;
      rename[s].wen = (r[1:0] != 2'b00);
      rename[s].areg = rat_pkg::areg_t'($urandom % `RAT_NUM_AREGS);
      rename[s].tag = r[`RAT_TAG_W+1:2];
      r = $urandom;
      rename[s].fun = r[`RAT_FUN_W-1:0];
      rename[s].grp_idx = g[s][`RAT_GRP_IDX_W-1:0];
      if (rename[s].wen)
      begin
        recent.push_back(rename[s].tag);
        if (recent.size() > 16)
          void'(recent.pop_front());
      end
    end
    if (($urandom % 7) == 0)
      rename[2].areg = rename[0].areg;
    for (int t = 0; t < `RAT_RET_PORTS; t++)
    begin
      retire[t].wen = ($urandom % 2) == 1;
      if (recent.size() > 0 && ($urandom % 4) != 0)
        retire[t].tag = recent[$urandom % recent.size()];
      else
      begin
        r = $urandom;
        retire[t].tag = r[`RAT_TAG_W-1:0];
      end
    end
  endtask

  task automatic wait_for_checks(input int target, input int limit);
    int n;
    n = 0;
    while (checks < target && n < limit)
    begin
      next_cycle();
      n++;
    end
    if (checks < target)
    begin
      $display("timeout: checker made only %0d comparisons, wanted %0d", checks, target);
      timeouts++;
    end
  endtask

  initial
  begin
    void'($urandom(34209));
    drive_idle();
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    wait_for_checks(3, 10);
    // sweep every register once before any rename
    for (int a = 0; a < `RAT_NUM_AREGS; a += 3)
    begin
      drive_idle();
      clk_en = 1'b1;
      for (int p = 0; p < `RAT_RD_PORTS; p++)
        read_areg[p] = rat_pkg::areg_t'((a + p < `RAT_NUM_AREGS) ? a + p : a);
      next_cycle();
    end
    start_checks = checks;
    for (int c = 0; c < NUM_CYCLES; c++)
    begin
      drive_random();
      next_cycle();
    end
    drive_idle();
    // the last captured addresses are compared one falling edge later
    wait_for_checks(start_checks + 3 * (NUM_CYCLES + 1), 10);
    $display("errors: %0d compare, %0d timeout, over %0d checks", cmp_errors, timeouts, checks);
    if (cmp_errors + timeouts == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: rat_checker.sv
`timescale 1ns/1ps
`include "rat_defs.svh"

module rat_checker (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  clk_en,
  input  rat_pkg::areg_t        read_areg [`RAT_RD_PORTS],
  input  rat_pkg::rename_slot_t rename [`RAT_WR_PORTS],
  input  rat_pkg::retire_slot_t retire [`RAT_RET_PORTS],
  input  logic                  retire_all,
  input  rat_pkg::read_result_t read_result [`RAT_RD_PORTS],
  output int                    errors,
  output int                    checks
);

  rat_pkg::entry_t model [`RAT_NUM_AREGS];
  rat_pkg::areg_t  addr_m [`RAT_RD_PORTS];
  string           last_evt [`RAT_NUM_AREGS];
  logic            held = 1'b0;
  logic            started = 1'b0;
  int              err_cnt = 0;
  int              chk_cnt = 0;

  assign errors = err_cnt;
  assign checks = chk_cnt;

  function automatic logic in_group(input rat_pkg::areg_t a);
    return a[`RAT_AREG_W-1 -: 2] == 2'b11;
  endfunction

  // expected result for a captured address, bypass uses this cycle's rename slots
  function automatic rat_pkg::read_result_t predict(input rat_pkg::areg_t a);
    rat_pkg::read_result_t res;
    logic found;
    res = '0;
    found = 1'b0;
    if (in_group(a))
    begin
      res.is_dep = 1'b1;
      res.tag = `RAT_TAG_RESET;
      res.fun = `RAT_FUN_RESET;
      for (int s = 0; s < `RAT_WR_PORTS; s++)
      begin
        if (!found && rename[s].grp_idx == a[`RAT_GRP_IDX_W-1:0])
        begin
          found = 1'b1;
          res.tag = rename[s].tag;
          res.fun = rename[s].fun;
        end
      end
    end
    else if (int'(a) < `RAT_NUM_AREGS)
    begin
      res.tag = model[a].tag;
      res.fun = model[a].fun;
      res.retired = model[a].retired;
    end
    return res;
  endfunction

  always @(posedge clk)
  begin
    rat_pkg::entry_t nxt;
    int hits;
    logic ret_hit;
    if (rst)
    begin
      for (int r = 0; r < `RAT_NUM_AREGS; r++)
      begin
        model[r].tag = `RAT_TAG_RESET;
        model[r].fun = `RAT_FUN_RESET;
        model[r].retired = 1'b1;
        last_evt[r] = "reset_values";
      end
      for (int p = 0; p < `RAT_RD_PORTS; p++)
        addr_m[p] = '0;
      held = 1'b0;
      started = 1'b1;
    end
    else
    begin
      for (int r = 0; r < `RAT_NUM_AREGS; r++)
      begin
        nxt = model[r];
        hits = 0;
        ret_hit = 1'b0;
        for (int s = 0; s < `RAT_WR_PORTS; s++)
        begin
          if (clk_en && rename[s].wen && rename[s].areg == rat_pkg::areg_t'(r))
          begin
            hits++;
            nxt.tag = rename[s].tag;
            nxt.fun = rename[s].fun;
          end
        end
        for (int t = 0; t < `RAT_RET_PORTS; t++)
        begin
          if (retire[t].wen && retire[t].tag == model[r].tag)
            ret_hit = 1'b1;
        end
        if (retire_all)
        begin
          nxt.retired = 1'b1;
          last_evt[r] = "retire_all";
        end
        else if (hits > 0)
        begin
          nxt.retired = 1'b0;
          last_evt[r] = (hits > 1) ? "rename_collision" : "rename";
        end
        else if (ret_hit)
        begin
          nxt.retired = 1'b1;
          last_evt[r] = "retire_tag";
        end
        model[r] = nxt;
      end
      if (clk_en)
        addr_m = read_areg;
      held = !clk_en;
    end
  end

  // outputs settle well before the falling edge
  always @(negedge clk)
  begin
    rat_pkg::read_result_t exp;
    string name;
    if (started)
    begin
      for (int p = 0; p < `RAT_RD_PORTS; p++)
      begin
        exp = predict(addr_m[p]);
        if (in_group(addr_m[p]))
          name = "in_group_bypass";
        else if (int'(addr_m[p]) >= `RAT_NUM_AREGS)
          name = "unmapped_read";
        else if (held)
          name = {"held_address ", last_evt[addr_m[p]]};
        else
          name = last_evt[addr_m[p]];
        if (read_result[p] !== exp)
        begin
          err_cnt++;
          $display("FAILED %s port %0d addr %0d: expected %h, actual %h",
                   name, p, addr_m[p], exp, read_result[p]);
        end
        chk_cnt++;
      end
    end
  end

endmodule

// File: rat.sv
`timescale 1ns/1ps
`include "rat_defs.svh"

module rat (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  clk_en,
  input  rat_pkg::areg_t        read_areg [`RAT_RD_PORTS],
  input  rat_pkg::rename_slot_t rename [`RAT_WR_PORTS],
  input  rat_pkg::retire_slot_t retire [`RAT_RET_PORTS],
  input  logic                  retire_all,
  output rat_pkg::read_result_t read_result [`RAT_RD_PORTS]
);

  localparam int SEL_W  = $clog2(`RAT_BANK_SIZE);
  localparam int BANK_W = `RAT_AREG_W - SEL_W;

  rat_pkg::areg_t        addr_q [`RAT_RD_PORTS];
  logic [SEL_W-1:0]      sel [`RAT_RD_PORTS];
  rat_pkg::entry_t       bank_state [`RAT_NUM_BANKS][`RAT_RD_PORTS];
  logic [`RAT_TAG_W-1:0] byp_tag [`RAT_RD_PORTS];
  logic [`RAT_FUN_W-1:0] byp_fun [`RAT_RD_PORTS];

  genvar b;
  genvar p;

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < `RAT_RD_PORTS; i++)
    begin
      if (rst)
        addr_q[i] <= '0;
      else if (clk_en)
        addr_q[i] <= read_areg[i];
    end
  end

  generate
    for (b = 0; b < `RAT_NUM_BANKS; b++)
    begin : g_bank
      rat_bank #(
        .BANK(b)
      ) u_bank (
        .clk       (clk),
        .rst       (rst),
        .clk_en    (clk_en),
        .rename    (rename),
        .retire    (retire),
        .retire_all(retire_all),
        .sel       (sel),
        .rd_state  (bank_state[b])
      );
    end

    for (p = 0; p < `RAT_RD_PORTS; p++)
    begin : g_port
      assign sel[p] = addr_q[p][SEL_W-1:0];

      rat_bypass u_bypass (
        .grp_idx(addr_q[p][`RAT_GRP_IDX_W-1:0]),
        .rename (rename),
        .tag    (byp_tag[p]),
        .fun    (byp_fun[p])
      );

      // in-group range first, then the bank holding the register, else zero
      always_comb
      begin
        read_result[p] = '0;
        if (addr_q[p][`RAT_AREG_W-1 -: 2] == 2'b11)
        begin
          read_result[p].tag    = byp_tag[p];
          read_result[p].fun    = byp_fun[p];
          read_result[p].is_dep = 1'b1;
        end
        else if (addr_q[p] < `RAT_AREG_W'(`RAT_NUM_AREGS))
        begin
          for (int k = 0; k < `RAT_NUM_BANKS; k++)
          begin
            if (addr_q[p][`RAT_AREG_W-1:SEL_W] == BANK_W'(k))
            begin
              read_result[p].tag     = bank_state[k][p].tag;
              read_result[p].fun     = bank_state[k][p].fun;
              read_result[p].retired = bank_state[k][p].retired;
            end
          end
        end
      end
    end
  endgenerate

endmodule

// File: rat_bypass.sv
`timescale 1ns/1ps
`include "rat_defs.svh"

module rat_bypass (
  input  logic [`RAT_GRP_IDX_W-1:0] grp_idx,
  input  rat_pkg::rename_slot_t     rename [`RAT_WR_PORTS],
  output logic [`RAT_TAG_W-1:0]     tag,
  output logic [`RAT_FUN_W-1:0]     fun
);

  // wen is ignored here, a producer in the group is a dependency either way
  logic                  hit;
  logic [`RAT_TAG_W-1:0] hit_tag;
  logic [`RAT_FUN_W-1:0] hit_fun;

  // walk from the top down so the lowest matching slot ends up selected
  always_comb
  begin
    hit     = 1'b0;
    hit_tag = '0;
    hit_fun = '0;
    for (int i = `RAT_WR_PORTS - 1; i >= 0; i--)
    begin
      if (rename[i].grp_idx == grp_idx)
      begin
        hit     = 1'b1;
        hit_tag = rename[i].tag;
        hit_fun = rename[i].fun;
      end
    end
  end

  // no producer in the group: look like a freshly reset entry
  assign tag = hit ? hit_tag : `RAT_TAG_RESET;
  assign fun = hit ? hit_fun : `RAT_FUN_RESET;

endmodule

// File: rat_bank.sv
`timescale 1ns/1ps
`include "rat_defs.svh"

module rat_bank #(
  parameter int BANK = 0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  clk_en,
  input  rat_pkg::rename_slot_t rename [`RAT_WR_PORTS],
  input  rat_pkg::retire_slot_t retire [`RAT_RET_PORTS],
  input  logic                  retire_all,
  input  logic [$clog2(`RAT_BANK_SIZE)-1:0] sel [`RAT_RD_PORTS],
  output rat_pkg::entry_t       rd_state [`RAT_RD_PORTS]
);

  localparam int SEL_W = $clog2(`RAT_BANK_SIZE);

  rat_pkg::entry_t entry_state [`RAT_BANK_SIZE];

  genvar e;
  genvar p;

  generate
    for (e = 0; e < `RAT_BANK_SIZE; e++)
    begin : g_entry
      rat_entry #(
        .REG_NUM(BANK * `RAT_BANK_SIZE + e)
      ) u_entry (
        .clk       (clk),
        .rst       (rst),
        .clk_en    (clk_en),
        .rename    (rename),
        .retire    (retire),
        .retire_all(retire_all),
        .state     (entry_state[e])
      );
    end

    // one eight-way select per read port
    for (p = 0; p < `RAT_RD_PORTS; p++)
    begin : g_rd
      always_comb
      begin
        rd_state[p] = entry_state[0];
        for (int k = 1; k < `RAT_BANK_SIZE; k++)
        begin
          if (sel[p] == SEL_W'(k))
            rd_state[p] = entry_state[k];
        end
      end
    end
  endgenerate

endmodule

// File: rat_entry.sv
`timescale 1ns/1ps
`include "rat_defs.svh"

module rat_entry #(
  parameter int REG_NUM = 0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  clk_en,
  input  rat_pkg::rename_slot_t rename [`RAT_WR_PORTS],
  input  rat_pkg::retire_slot_t retire [`RAT_RET_PORTS],
  input  logic                  retire_all,
  output rat_pkg::entry_t       state
);

  localparam rat_pkg::areg_t MY_AREG = rat_pkg::areg_t'(REG_NUM);

  logic                  ren_hit;
  logic [`RAT_TAG_W-1:0] ren_tag;
  logic [`RAT_FUN_W-1:0] ren_fun;
  logic                  ret_hit;

  // later slots override earlier ones, so the highest match wins
  always_comb
  begin
    ren_hit = 1'b0;
    ren_tag = '0;
    ren_fun = '0;
    for (int i = 0; i < `RAT_WR_PORTS; i++)
    begin
      if (rename[i].wen && clk_en && (rename[i].areg == MY_AREG))
      begin
        ren_hit = 1'b1;
        ren_tag = rename[i].tag;
        ren_fun = rename[i].fun;
      end
    end
  end

  // retire only counts against the tag currently held
  always_comb
  begin
    ret_hit = 1'b0;
    for (int j = 0; j < `RAT_RET_PORTS; j++)
    begin
      if (retire[j].wen && (retire[j].tag == state.tag))
        ret_hit = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state.tag     <= `RAT_TAG_RESET;
      state.fun     <= `RAT_FUN_RESET;
      state.retired <= 1'b1;
    end
    else
    begin
      if (ren_hit)
      begin
        state.tag <= ren_tag;
        state.fun <= ren_fun;
      end
      // retire_all beats a rename, a rename beats a tag retire
      if (retire_all)
        state.retired <= 1'b1;
      else if (ren_hit)
        state.retired <= 1'b0;
      else if (ret_hit)
        state.retired <= 1'b1;
    end
  end

endmodule

// File: rat_pkg.sv
`include "rat_defs.svh"

package rat_pkg;

  typedef logic [`RAT_AREG_W-1:0] areg_t;

  // one rename slot of the current group
  typedef struct packed {
    logic                     wen;
    areg_t                    areg;
    logic [`RAT_TAG_W-1:0]     tag;
    logic [`RAT_FUN_W-1:0]     fun;
    logic [`RAT_GRP_IDX_W-1:0] grp_idx;
  } rename_slot_t;

  typedef struct packed {
    logic                 wen;
    logic [`RAT_TAG_W-1:0] tag;
  } retire_slot_t;

  typedef struct packed {
    logic [`RAT_TAG_W-1:0] tag;
    logic [`RAT_FUN_W-1:0] fun;
    logic                 retired;
    logic                 is_dep;
  } read_result_t;

  // stored state of one architectural register
  typedef struct packed {
    logic [`RAT_TAG_W-1:0] tag;
    logic [`RAT_FUN_W-1:0] fun;
    logic                 retired;
  } entry_t;

endpackage

// File: rat_defs.svh
`ifndef RAT_DEFS_SVH
`define RAT_DEFS_SVH

// table geometry
`define RAT_NUM_AREGS 40
`define RAT_BANK_SIZE 8
`define RAT_NUM_BANKS 5

// field widths
`define RAT_AREG_W 6
`define RAT_TAG_W 9
`define RAT_FUN_W 10
`define RAT_GRP_IDX_W 4

// port counts
`define RAT_RD_PORTS 3
`define RAT_WR_PORTS 3
`define RAT_RET_PORTS 3

// values an entry holds after reset
`define RAT_TAG_RESET {`RAT_TAG_W{1'b1}}
`define RAT_FUN_RESET {1'b0, {(`RAT_FUN_W-1){1'b1}}}

`endif
